/* ldpc_enc_defines.svh */
`ifndef LDPC_ENC_DEFINES_SVH
`define LDPC_ENC_DEFINES_SVH

// Width of one data word on every stream and in the output buffer.
`define LDPC_DAT_W  8

// Buffer address width. The buffer holds 2**LDPC_ADDR_W words, so a frame of
// LDPC_MAX_K systematic words plus three parity words always fits.
`define LDPC_ADDR_W 5

// Frame tag width. The tag rides with the frame from input to readout.
`define LDPC_TAG_W  2

// Largest number of systematic words in one frame.
// The smallest legal frame has two words.
`define LDPC_MAX_K  16

`endif

/* ldpc_enc_pkg.sv */
`default_nettype none

`include "ldpc_enc_defines.svh"

package ldpc_enc_pkg;

  // One data word.
  typedef logic [`LDPC_DAT_W-1:0] dat_t;

  // Frame delimiters carried next to each word.
  typedef struct packed {
    logic sof;  // First word of a frame.
    logic eof;  // Last word of a stream.
  } strb_t;

  // Per-frame code context, 7 bits in all.
  typedef struct packed {
    logic [`LDPC_ADDR_W-1:0] k_words;   // Systematic words, 2 to 16.
    logic                    nparity;   // 0 gives two parity words, 1 gives three.
    logic                    do_punct;  // Drop the first systematic word on output.
  } code_ctx_t;

  // The systematic stream.
  // pmask flags a word that is removed from the output when puncturing is on.
  typedef struct packed {
    logic  val;
    logic  pmask;
    strb_t strb;
    dat_t  dat;
  } sys_word_t;

  // One parity stream. Only the last parity word of a frame carries eof.
  typedef struct packed {
    logic  val;
    strb_t strb;
    dat_t  dat;
  } par_word_t;

  // Write port of the output buffer.
  typedef struct packed {
    logic                    write;  // Store wdat at waddr.
    logic                    wfull;  // This write closes the frame.
    logic [`LDPC_ADDR_W-1:0] waddr;
    dat_t                    wdat;
  } buf_wr_t;

endpackage

`default_nettype wire

/* ldpc_enc_sys_feeder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module ldpc_enc_sys_feeder
  import ldpc_enc_pkg::*;
(
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   in_val,
  input  strb_t                  in_strb,
  input  dat_t                   in_dat,
  input  logic [`LDPC_TAG_W-1:0] in_tag,
  input  code_ctx_t              in_ctx,
  output sys_word_t              sys,
  output logic [`LDPC_TAG_W-1:0] tag,
  output code_ctx_t              code_ctx
);

  logic  sys_val;    // Registered word valid.
  logic  sys_pmask;  // Registered puncture mark.
  strb_t sys_strb;   // Registered delimiters.
  dat_t  sys_dat;    // Registered word.
  logic  in_sof;     // Input word opens a frame.

  assign in_sof = in_val & in_strb.sof;

  // Control side of the input register.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sys_val   <= 1'b0;
      sys_pmask <= 1'b0;
      sys_strb  <= '0;
      code_ctx  <= '0;
    end
    else if (iclkena) begin
      sys_val   <= in_val;
      // Only the first word of a frame is ever punctured.
      sys_pmask <= in_sof & in_ctx.do_punct;
      sys_strb  <= in_strb;
      // The context steers the muxout and the parity length, so it stays
      // fixed from this sof until the next one.
      if (in_sof) begin
        code_ctx <= in_ctx;
      end
    end
  end

  // Data side of the input register.
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      sys_dat <= in_dat;
      if (in_sof) begin
        tag <= in_tag;  // The tag follows the frame to the buffer.
      end
    end
  end

  // Word, mark and delimiters leave together on one cycle.
  assign sys = '{val: sys_val, pmask: sys_pmask, strb: sys_strb, dat: sys_dat};

endmodule

`default_nettype wire

/* ldpc_enc_parity_acc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module ldpc_enc_parity_acc
  import ldpc_enc_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  sys_word_t sys,
  input  code_ctx_t code_ctx,
  output par_word_t p1,
  output par_word_t p2,
  output par_word_t p3
);

  localparam int idx_w = $clog2(`LDPC_MAX_K);  // Word index inside a frame.
  localparam int rot_w = $clog2(`LDPC_DAT_W);  // Rotation amount for p2.

  logic [idx_w-1:0] idx;       // Index of the next systematic word.
  logic [idx_w-1:0] idx_base;  // Index of the word on sys now.
  logic [rot_w-1:0] rot;       // Index modulo the word width.
  logic             restart;   // A new frame starts on sys.
  dat_t             acc1;
  dat_t             acc2;
  dat_t             acc3;
  dat_t             acc1_nxt;
  dat_t             acc2_nxt;
  dat_t             acc3_nxt;
  dat_t             dat_rot;
  logic [1:0]       pcnt;      // Parity emission counter, 0 when idle.
  logic [1:0]       plast;     // Last counter state of this frame.

  assign restart  = sys.strb.sof;
  assign idx_base = restart ? '0 : idx;
  assign rot      = rot_w'(idx_base % `LDPC_DAT_W);

  // Rotate left. A zero rotation shifts the right part out completely.
  assign dat_rot = dat_t'((sys.dat << rot) | (sys.dat >> (`LDPC_DAT_W - rot)));

  // The sof word starts every sum from zero.
  // Punctured words are counted like any other.
  always_comb begin
    acc1_nxt = (restart ? '0 : acc1) ^ sys.dat;
    acc2_nxt = (restart ? '0 : acc2) ^ dat_rot;
    acc3_nxt = restart ? '0 : acc3;
    if (!idx_base[0]) begin
      acc3_nxt = acc3_nxt ^ sys.dat;  // Even index words only.
    end
  end

  // The sums hold after eof until the counter has emitted them.
  always_ff @(posedge iclk) begin
    if (iclkena && sys.val) begin
      acc1 <= acc1_nxt;
      acc2 <= acc2_nxt;
      acc3 <= acc3_nxt;
    end
  end

  assign plast = code_ctx.nparity ? 2'd3 : 2'd2;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      idx  <= '0;
      pcnt <= 2'd0;
    end
    else if (iclkena) begin
      if (sys.val) begin
        idx <= idx_base + 1'b1;
      end
      // State 1 shows p1, 2 shows p2 and 3 shows p3.
      if (sys.val && sys.strb.eof) begin
        pcnt <= 2'd1;
      end
      else if (pcnt == plast || pcnt == 2'd0) begin
        pcnt <= 2'd0;
      end
      else begin
        pcnt <= pcnt + 2'd1;
      end
    end
  end

  // Each parity stream is a decode of the counter and one sum.
  assign p1 = '{val: (pcnt == 2'd1), strb: '{sof: 1'b0, eof: 1'b0}, dat: acc1};
  assign p2 = '{val: (pcnt == 2'd2), strb: '{sof: 1'b0, eof: !code_ctx.nparity}, dat: acc2};
  assign p3 = '{val: (pcnt == 2'd3), strb: '{sof: 1'b0, eof: 1'b1}, dat: acc3};

endmodule

`default_nettype wire

/* ldpc_enc_muxout.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module ldpc_enc_muxout
  import ldpc_enc_pkg::*;
(
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic [`LDPC_TAG_W-1:0] tag,
  input  code_ctx_t              code_ctx,
  input  sys_word_t              sys,
  input  par_word_t              p1,
  input  par_word_t              p2,
  input  par_word_t              p3,
  output buf_wr_t                wr,
  output logic [`LDPC_TAG_W-1:0] owtag,
  output code_ctx_t              ocode_ctx
);

  localparam int addr_w = `LDPC_ADDR_W;

  logic              mux_write;   // Some stream has a word to store.
  logic              mux_wstart;  // Frame start seen on the systematic stream.
  logic              mux_wfull;   // Last parity word of the frame.
  dat_t              mux_wdat;    // Word picked by priority.
  logic              write;
  logic              wfull;
  logic [addr_w-1:0] waddr;
  dat_t              wdat;

  assign mux_wstart = sys.val & sys.strb.sof;

  // Either p2 or p3 closes the frame, depending on nparity.
  assign mux_wfull = (p2.val & p2.strb.eof) | (p3.val & p3.strb.eof);

  always_comb begin
    // A masked systematic word is dropped only when puncturing is on.
    if (code_ctx.do_punct) begin
      mux_write = (sys.val & !sys.pmask) | p1.val | p2.val | p3.val;
    end
    else begin
      mux_write = sys.val | p1.val | p2.val | p3.val;
    end
    // The streams never overlap in normal use.
    // Parity still wins if they do.
    mux_wdat = sys.dat;
    if (p3.val) begin
      mux_wdat = p3.dat;
    end
    else if (p2.val) begin
      mux_wdat = p2.dat;
    end
    else if (p1.val) begin
      mux_wdat = p1.dat;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      write <= 1'b0;
      wfull <= 1'b0;
    end
    else if (iclkena) begin
      write <= mux_write;
      wfull <= mux_wfull;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      wdat  <= mux_wdat;
      // The address moves only after a real write, so a punctured sof word
      // leaves the next word at address 0.
      waddr <= mux_wstart ? '0 : (waddr + addr_w'(write));
      // Tag and context of the frame in flight.
      if (mux_wstart) begin
        owtag     <= tag;
        ocode_ctx <= code_ctx;
      end
    end
  end

  assign wr = '{write: write, wfull: wfull, waddr: waddr, wdat: wdat};

endmodule

`default_nettype wire

/* ldpc_enc_out_buf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module ldpc_enc_out_buf
  import ldpc_enc_pkg::*;
(
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    iclkena,
  input  buf_wr_t                 wr,
  input  logic [`LDPC_TAG_W-1:0]  owtag,
  input  logic                    frame_ack,
  input  logic [`LDPC_ADDR_W-1:0] rd_addr,
  output dat_t                    rd_dat,
  output logic                    frame_ready,
  output logic [`LDPC_ADDR_W-1:0] frame_len,
  output logic [`LDPC_TAG_W-1:0]  frame_tag
);

  localparam int depth = 2 ** `LDPC_ADDR_W;

  dat_t mem [depth];  // One frame of words.
  logic frame_done;   // The closing write of a frame.

  assign frame_done = wr.write & wr.wfull;

  // Storage, frame description and the read port.
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr.write) begin
        mem[wr.waddr] <= wr.wdat;
      end
      if (frame_done) begin
        frame_len <= wr.waddr + 1'b1;  // Addresses start at 0.
        frame_tag <= owtag;
      end
      rd_dat <= mem[rd_addr];  // One cycle of read latency.
    end
  end

  // The frame is ready from the edge that stores its last word
  // until the reader acknowledges it.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      frame_ready <= 1'b0;
    end
    else if (iclkena) begin
      if (frame_done) begin
        frame_ready <= 1'b1;
      end
      else if (frame_ack) begin
        frame_ready <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* ldpc_enc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module ldpc_enc_top
  import ldpc_enc_pkg::*;
(
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    iclkena,
  input  logic                    in_val,
  input  strb_t                   in_strb,
  input  dat_t                    in_dat,
  input  logic [`LDPC_TAG_W-1:0]  in_tag,
  input  code_ctx_t               in_ctx,
  input  logic                    frame_ack,
  input  logic [`LDPC_ADDR_W-1:0] rd_addr,
  output dat_t                    rd_dat,
  output logic                    frame_ready,
  output logic [`LDPC_ADDR_W-1:0] frame_len,
  output logic [`LDPC_TAG_W-1:0]  frame_tag
);

  sys_word_t              sys;       // Registered systematic stream.
  logic [`LDPC_TAG_W-1:0] sys_tag;   // Tag of the frame on sys.
  code_ctx_t              sys_ctx;   // Context of the frame on sys.
  par_word_t              p1;
  par_word_t              p2;
  par_word_t              p3;
  buf_wr_t                wr;        // Numbered write stream.
  logic [`LDPC_TAG_W-1:0] wr_tag;    // Tag of the frame being written.

  ldpc_enc_sys_feeder sys_feeder_i (
    .iclk     ( iclk     ),
    .ireset   ( ireset   ),
    .iclkena  ( iclkena  ),
    .in_val   ( in_val   ),
    .in_strb  ( in_strb  ),
    .in_dat   ( in_dat   ),
    .in_tag   ( in_tag   ),
    .in_ctx   ( in_ctx   ),
    .sys      ( sys      ),
    .tag      ( sys_tag  ),
    .code_ctx ( sys_ctx  )
  );

  ldpc_enc_parity_acc parity_acc_i (
    .iclk     ( iclk     ),
    .ireset   ( ireset   ),
    .iclkena  ( iclkena  ),
    .sys      ( sys      ),
    .code_ctx ( sys_ctx  ),
    .p1       ( p1       ),
    .p2       ( p2       ),
    .p3       ( p3       )
  );

  // The buffer needs no code context, so that output stays open.
  ldpc_enc_muxout muxout_i (
    .iclk      ( iclk    ),
    .ireset    ( ireset  ),
    .iclkena   ( iclkena ),
    .tag       ( sys_tag ),
    .code_ctx  ( sys_ctx ),
    .sys       ( sys     ),
    .p1        ( p1      ),
    .p2        ( p2      ),
    .p3        ( p3      ),
    .wr        ( wr      ),
    .owtag     ( wr_tag  ),
    .ocode_ctx (         )
  );

  ldpc_enc_out_buf out_buf_i (
    .iclk        ( iclk        ),
    .ireset      ( ireset      ),
    .iclkena     ( iclkena     ),
    .wr          ( wr          ),
    .owtag       ( wr_tag      ),
    .frame_ack   ( frame_ack   ),
    .rd_addr     ( rd_addr     ),
    .rd_dat      ( rd_dat      ),
    .frame_ready ( frame_ready ),
    .frame_len   ( frame_len   ),
    .frame_tag   ( frame_tag   )
  );

endmodule

`default_nettype wire

/* tb_ldpc_enc_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module tb_ldpc_enc_assertions
  import ldpc_enc_pkg::*;
(
  input logic                    iclk,
  input logic                    ireset,
  input logic                    iclkena,
  input logic                    in_val,
  input strb_t                   in_strb,
  input logic                    frame_ready,
  input logic [`LDPC_ADDR_W-1:0] frame_len,
  input buf_wr_t                 wr
);

  logic       in_sof;     // A frame start is taken on this edge.
  logic       in_eof;     // A frame end is taken on this edge.
  logic [2:0] since_eof;  // Enabled cycles since the last input eof. It saturates at 7.

  assign in_sof = iclkena & in_val & in_strb.sof;
  assign in_eof = iclkena & in_val & in_strb.eof;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      since_eof <= 3'd7;  // No frame seen yet, so the first sof is always legal.
    end
    else if (in_eof) begin
      since_eof <= 3'd0;
    end
    else if (iclkena && since_eof != 3'd7) begin
      since_eof <= since_eof + 3'd1;
    end
  end

  // The buffer holds one frame only, so a new frame must wait for the ack.
  sof_when_ready: assert property (@(posedge iclk) disable iff (ireset)
    in_sof |-> !frame_ready)
    else $error("frame start while the buffer still holds a ready frame");

  // The parity tail needs four cycles to drain before the next sof.
  sof_spacing: assert property (@(posedge iclk) disable iff (ireset)
    in_sof |-> (since_eof >= 3'd3))
    else $error("frame start less than four cycles after the previous eof");

  waddr_in_frame: assert property (@(posedge iclk) disable iff (ireset)
    (frame_ready && wr.write) |-> (wr.waddr < frame_len))
    else $error("write address beyond the length of the ready frame");

  // Reset clears the feeder and the parity counter as well.
  // Nothing reaches the buffer in the first two cycles after release.
  reset_clears: assert property (@(posedge iclk)
    $past(ireset, 2) |-> (!wr.write && !frame_ready))
    else $error("write or frame_ready set right after reset");

endmodule

bind ldpc_enc_top tb_ldpc_enc_assertions assertions_i (
  .iclk        ( iclk        ),
  .ireset      ( ireset      ),
  .iclkena     ( iclkena     ),
  .in_val      ( in_val      ),
  .in_strb     ( in_strb     ),
  .frame_ready ( frame_ready ),
  .frame_len   ( frame_len   ),
  .wr          ( wr          )
);

`default_nettype wire

/* tb_ldpc_enc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldpc_enc_defines.svh"

module tb_ldpc_enc
  import ldpc_enc_pkg::*;
();

  typedef logic [`LDPC_ADDR_W-1:0] addr_t;
  typedef logic [`LDPC_TAG_W-1:0]  tag_t;

  // One frame per row. The seed picks a slice of the random word pool.
  typedef struct packed {
    logic [4:0] k;      // Systematic words.
    logic       npar;   // Three parity words when set.
    logic       punct;  // Drop the first systematic word.
    tag_t       tag;
    logic [2:0] seed;
    logic       gap;    // Hold iclkena low in the middle of the frame.
  } row_t;

  localparam int   n_rows = 9;
  localparam row_t rows [n_rows] = '{
    '{5'd4,  1'b1, 1'b0, 2'd1, 3'd0, 1'b0},  // Plain frame with p1, p2 and p3.
    '{5'd5,  1'b0, 1'b0, 2'd2, 3'd1, 1'b0},  // Two parity words.
    '{5'd6,  1'b1, 1'b1, 2'd3, 3'd2, 1'b0},  // Punctured.
    '{5'd16, 1'b1, 1'b0, 2'd0, 3'd3, 1'b0},  // Largest frame.
    '{5'd16, 1'b0, 1'b0, 2'd1, 3'd7, 1'b0},  // Other words over the same addresses.
    '{5'd16, 1'b1, 1'b0, 2'd2, 3'd3, 1'b1},  // Largest frame again with a clock enable gap.
    '{5'd2,  1'b0, 1'b1, 2'd1, 3'd4, 1'b0},  // Smallest frame, punctured.
    '{5'd9,  1'b0, 1'b1, 2'd3, 3'd5, 1'b1},
    '{5'd11, 1'b1, 1'b1, 2'd0, 3'd6, 1'b0}
  };

  logic      iclk;
  logic      ireset;
  logic      iclkena;
  logic      in_val;
  strb_t     in_strb;
  dat_t      in_dat;
  tag_t      in_tag;
  code_ctx_t in_ctx;
  logic      frame_ack;
  addr_t     rd_addr;
  dat_t      rd_dat;
  logic      frame_ready;
  addr_t     frame_len;
  tag_t      frame_tag;

  dat_t pool [128];  // Random words. Each seed owns 16 of them.
  dat_t exp_q [$];   // Expected buffer contents of the current frame.
  int   errors;
  int   checks;
  int   failed;

  ldpc_enc_top dut_i (.*);

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  function automatic dat_t rotl(dat_t d, int s);
    dat_t r;
    for (int b = 0; b < `LDPC_DAT_W; b++) begin
      r[(b + s) % `LDPC_DAT_W] = d[b];  // Bit b moves s places up and wraps at the top.
    end
    return r;
  endfunction

  // Reference model. Parity covers every word.
  // Puncturing only drops the first word from the list.
  function automatic void build_expected(row_t r);
    dat_t w;
    dat_t s1;
    dat_t s2;
    dat_t s3;
    s1 = '0;
    s2 = '0;
    s3 = '0;
    exp_q.delete();
    for (int i = 0; i < int'(r.k); i++) begin
      w  = pool[int'(r.seed) * 16 + i];
      s1 = s1 ^ w;
      s2 = s2 ^ rotl(w, i % `LDPC_DAT_W);
      if (i % 2 == 0) begin
        s3 = s3 ^ w;  // Even positions only.
      end
      if (!(r.punct && i == 0)) begin
        exp_q.push_back(w);
      end
    end
    exp_q.push_back(s1);
    exp_q.push_back(s2);
    if (r.npar) begin
      exp_q.push_back(s3);
    end
  endfunction

  task automatic check_dat(string name, dat_t got, dat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_len(string name, addr_t got, addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_tag(string name, tag_t got, tag_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_cycles(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic send_frame(row_t r);
    for (int i = 0; i < int'(r.k); i++) begin
      @(posedge iclk);
      if (r.gap && i == int'(r.k) / 2) begin
        iclkena <= 1'b0;  // The previous word is taken on this edge, then all holds.
        repeat (3) @(posedge iclk);
        iclkena <= 1'b1;
      end
      in_val  <= 1'b1;
      in_strb <= '{sof: (i == 0), eof: (i == int'(r.k) - 1)};
      in_dat  <= pool[int'(r.seed) * 16 + i];
      in_tag  <= r.tag;
      in_ctx  <= '{k_words: r.k, nparity: r.npar, do_punct: r.punct};
    end
  endtask

  // Counts edges from the one that drives eof until frame_ready is seen high.
  task automatic wait_ready(output int lat);
    lat = 0;
    do begin
      @(posedge iclk);
      in_val  <= 1'b0;
      in_strb <= '0;
      lat++;
      @(negedge iclk);  // Outputs are stable here.
    end while (!frame_ready && lat < 20);
    if (!frame_ready) begin
      errors++;
      $display("frame_ready did not rise within 20 cycles after eof at %0t", $time);
    end
  endtask

  task automatic read_frame();
    for (int a = 0; a < exp_q.size(); a++) begin
      @(posedge iclk);
      rd_addr <= addr_t'(a);
      @(posedge iclk);  // One cycle of read latency.
      @(negedge iclk);
      check_dat($sformatf("rd_dat[%0d]", a), rd_dat, exp_q[a]);
    end
  endtask

  task automatic ack_frame();
    @(posedge iclk);
    frame_ack <= 1'b1;
    @(posedge iclk);
    frame_ack <= 1'b0;
    @(negedge iclk);
    checks++;
    if (frame_ready) begin
      errors++;
      $display("frame_ready stayed high after frame_ack at %0t", $time);
    end
  endtask

  initial begin
    int lat;
    int err0;
    ireset    = 1'b1;
    iclkena   = 1'b1;
    in_val    = 1'b0;
    in_strb   = '0;
    in_dat    = '0;
    in_tag    = '0;
    in_ctx    = '0;
    frame_ack = 1'b0;
    rd_addr   = '0;
    errors    = 0;
    checks    = 0;
    failed    = 0;
    void'($urandom(32'h3bb5_58cd));
    foreach (pool[j]) begin
      pool[j] = dat_t'($urandom);
    end
    repeat (4) @(posedge iclk);
    ireset <= 1'b0;
    repeat (2) @(posedge iclk);
    for (int t = 0; t < n_rows; t++) begin
      err0 = errors;
      build_expected(rows[t]);
      send_frame(rows[t]);
      wait_ready(lat);
      check_cycles("eof to frame_ready", lat, rows[t].npar ? 6 : 5);
      check_len("frame_len", frame_len, addr_t'(exp_q.size()));
      check_tag("frame_tag", frame_tag, rows[t].tag);
      read_frame();
      ack_frame();
      if (errors != err0) begin
        failed++;
      end
      $display("test %0d k=%0d nparity=%0d punct=%0d gap=%0d: %s", t, rows[t].k,
               rows[t].npar, rows[t].punct, rows[t].gap, (errors == err0) ? "ok" : "mismatch");
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_rows, failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end
    else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table. Each cycle is one 20 ns period.
  initial begin
    int limit;
    limit = 20;  // Reset and start up.
    for (int t = 0; t < n_rows; t++) begin
      limit += 3 * (int'(rows[t].k) + 3) + 40;
    end
    #(limit * 20);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
ldpc_enc_pkg.sv
ldpc_enc_sys_feeder.sv
ldpc_enc_parity_acc.sv
ldpc_enc_muxout.sv
ldpc_enc_out_buf.sv
ldpc_enc_top.sv
tb_ldpc_enc_assertions.sv
tb_ldpc_enc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ldpc_enc
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) ldpc_enc_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
